/* sim.f */
+incdir+src
+incdir+verification
src/rv_isa_pkg.sv
src/id_pipe_pkg.sv
src/id_decoder.sv
src/id_gpr_file.sv
src/id_hazard_check.sv
src/id_branch_unit.sv
src/id_stage.sv
verification/tb_id_stage.sv

/* verification/tb_id_checks.svh */
// compare tasks for tb_id_stage, included inside the module; the run stops at the first error
`ifndef TB_ID_CHECKS_SVH
`define TB_ID_CHECKS_SVH

task automatic abort_run(input string reason);
  $display("%s", reason);
  $display("*** FAILED ***");
  $fatal(1, "simulation stopped");
endtask

task automatic check_ds_to_es(input string                  name,
                              input id_pipe_pkg::ds_to_es_t exp,
                              input id_pipe_pkg::ds_to_es_t act);
  if (act !== exp) begin
    abort_run($sformatf("Mismatch %s: expected %h, actual %h", name, exp, act));
  end
endtask

task automatic check_br(input string                name,
                        input id_pipe_pkg::br_bus_t exp,
                        input id_pipe_pkg::br_bus_t act);
  if (act !== exp) begin
    abort_run($sformatf("Mismatch %s: expected %h, actual %h", name, exp, act));
  end
endtask

// single flags such as valid, allowin and ctrl bits
task automatic check_valid(input string name, input bit exp, input bit act);
  if (act !== exp) begin
    abort_run($sformatf("Mismatch %s: expected %b, actual %b", name, exp, act));
  end
endtask

`endif

/* verification/tb_id_stage.sv */
// directed tests for id_stage; x1..x31 are written first, so expected reads come from the model
`timescale 1ns/1ns
`include "id_defines.svh"

module tb_id_stage;

  localparam int TIMEOUT = 40; // cycles allowed per wait

  logic                   i_clk = 1'b0;
  logic                   i_rst;
  logic                   i_fs_to_ds_valid;
  id_pipe_pkg::fs_to_ds_t i_fs_to_ds;
  logic                   i_es_allowin;
  id_pipe_pkg::wb_to_rf_t i_wb_to_rf;
  rv_isa_pkg::reg_addr_t  i_es_rd;
  rv_isa_pkg::reg_addr_t  i_ms_rd;
  rv_isa_pkg::reg_addr_t  i_ws_rd;
  logic                   o_ds_allowin;
  logic                   o_ds_to_es_valid;
  id_pipe_pkg::ds_to_es_t o_ds_to_es;
  id_pipe_pkg::br_bus_t   o_br_bus;

  rv_isa_pkg::xlen_t gpr_model [`NUM_GPR];
  integer            seed;

  `include "tb_id_checks.svh"

  id_stage u_id_stage (
    .i_clk            (i_clk),
    .i_rst            (i_rst),
    .i_fs_to_ds_valid (i_fs_to_ds_valid),
    .i_fs_to_ds       (i_fs_to_ds),
    .i_es_allowin     (i_es_allowin),
    .i_wb_to_rf       (i_wb_to_rf),
    .i_es_rd          (i_es_rd),
    .i_ms_rd          (i_ms_rd),
    .i_ws_rd          (i_ws_rd),
    .o_ds_allowin     (o_ds_allowin),
    .o_ds_to_es_valid (o_ds_to_es_valid),
    .o_ds_to_es       (o_ds_to_es),
    .o_br_bus         (o_br_bus)
  );

  always #50 i_clk = ~i_clk;

  function automatic rv_isa_pkg::xlen_t rand64();
    return {$random(seed), $random(seed)};
  endfunction

  function automatic rv_isa_pkg::xlen_t sext12(input logic [11:0] v);
    return {{(`XLEN-12){v[11]}}, v};
  endfunction

  function automatic rv_isa_pkg::xlen_t rd_model(input rv_isa_pkg::reg_addr_t a);
    return (a == '0) ? '0 : gpr_model[a];
  endfunction

  // ctrl of a plain register-writing alu instruction
  function automatic id_pipe_pkg::ctrl_t alu_ctrl(input rv_isa_pkg::src1_sel_e s1,
                                                  input rv_isa_pkg::src2_sel_e s2,
                                                  input rv_isa_pkg::alu_op_e   op,
                                                  input rv_isa_pkg::reg_addr_t rd);
    id_pipe_pkg::ctrl_t c;
    c          = '0;
    c.src1_sel = s1;
    c.src2_sel = s2;
    c.alu_op   = op;
    c.rd       = rd;
    c.gpr_wen  = 1'b1;
    return c;
  endfunction

  function automatic id_pipe_pkg::ds_to_es_t exp_bus(input rv_isa_pkg::inst_t  inst,
                                                      input rv_isa_pkg::xlen_t  pc,
                                                      input rv_isa_pkg::xlen_t  imm,
                                                      input id_pipe_pkg::ctrl_t c);
    id_pipe_pkg::ds_to_es_t e;
    e.rs1_data = rd_model(inst[19:15]);
    e.rs2_data = rd_model(inst[24:20]);
    e.imm      = imm;
    e.pc       = pc;
    e.ctrl     = c;
    return e;
  endfunction

  task automatic write_gpr(input rv_isa_pkg::reg_addr_t a, input rv_isa_pkg::xlen_t d);
    @(negedge i_clk);
    i_wb_to_rf = '{wen: 1'b1, waddr: a, wdata: d};
    @(negedge i_clk);
    i_wb_to_rf.wen = 1'b0;
    if (a != '0) gpr_model[a] = d;
  endtask

  task automatic set_hazards(input rv_isa_pkg::reg_addr_t es, input rv_isa_pkg::reg_addr_t ms,
                             input rv_isa_pkg::reg_addr_t ws);
    @(negedge i_clk);
    i_es_rd = es;
    i_ms_rd = ms;
    i_ws_rd = ws;
  endtask

  // hand one item over, returns in the cycle it sits in the stage
  task automatic issue(input rv_isa_pkg::inst_t inst, input rv_isa_pkg::xlen_t pc);
    int n;
    n = 0;
    @(negedge i_clk);
    i_fs_to_ds_valid = 1'b1;
    i_fs_to_ds       = '{inst: inst, pc: pc};
    #10;
    while (!o_ds_allowin) begin
      n++;
      if (n > TIMEOUT) abort_run("timeout: the stage never accepted an item");
      @(negedge i_clk);
      #10;
    end
    @(negedge i_clk); // taken at the rising edge in between
    i_fs_to_ds_valid = 1'b0;
    #10;
  endtask

  task automatic wait_out_valid(input string name);
    int n;
    n = 0;
    while (!o_ds_to_es_valid) begin
      n++;
      if (n > TIMEOUT) abort_run({"timeout: output valid never rose in ", name});
      @(negedge i_clk);
      #10;
    end
  endtask

  task automatic stall_then_release(input string name);
    repeat (3) begin
      check_valid({name, " stalled"}, 1'b0, o_ds_to_es_valid);
      check_valid({name, " no redirect"}, 1'b0, o_br_bus.taken);
      @(negedge i_clk);
      #10;
    end
    set_hazards('0, '0, '0);
    #10;
    wait_out_valid(name);
  endtask

  task automatic decode_case(input string name, input rv_isa_pkg::inst_t inst,
                             input rv_isa_pkg::xlen_t imm, input id_pipe_pkg::ctrl_t c);
    rv_isa_pkg::xlen_t pc;
    pc = rand64() & ~64'h3;
    issue(inst, pc);
    check_valid(name, 1'b1, o_ds_to_es_valid);
    check_ds_to_es(name, exp_bus(inst, pc, imm, c), o_ds_to_es);
  endtask

  task automatic test_register_file();
    rv_isa_pkg::inst_t inst;
    for (int a = 1; a < `NUM_GPR; a++) write_gpr(a, rand64());
    write_gpr(5'd0, rand64()); // dropped, x0 stays zero
    inst = {7'b0000000, 5'd7, 5'd3, 3'b000, 5'd5, 7'b0110011};
    decode_case("add x5,x3,x7", inst, sext12(inst[31:20]),
                alu_ctrl(rv_isa_pkg::RS1, rv_isa_pkg::RS2, rv_isa_pkg::ADD, 5'd5));
    write_gpr(5'd3, rand64());
    decode_case("add after rewrite", inst, sext12(inst[31:20]),
                alu_ctrl(rv_isa_pkg::RS1, rv_isa_pkg::RS2, rv_isa_pkg::ADD, 5'd5));
    inst = {7'b0000000, 5'd31, 5'd0, 3'b000, 5'd6, 7'b0110011};
    decode_case("add x6,x0,x31", inst, sext12(inst[31:20]),
                alu_ctrl(rv_isa_pkg::RS1, rv_isa_pkg::RS2, rv_isa_pkg::ADD, 5'd6));
  endtask

  task automatic test_alu_decode();
    logic [11:0]       i12;
    logic [19:0]       u20;
    rv_isa_pkg::inst_t inst;
    for (int k = 0; k < 2; k++) begin
      i12     = $random(seed);
      u20     = $random(seed);
      i12[11] = k[0]; // both signs
      u20[19] = k[0];
      decode_case("addi", {i12, 5'd4, 3'b000, 5'd9, 7'b0010011}, sext12(i12),
                  alu_ctrl(rv_isa_pkg::RS1, rv_isa_pkg::IMM, rv_isa_pkg::ADD, 5'd9));
      decode_case("lui", {u20, 5'd12, 7'b0110111}, {{(`XLEN-32){u20[19]}}, u20, 12'b0},
                  alu_ctrl(rv_isa_pkg::RS1, rv_isa_pkg::IMM, rv_isa_pkg::PASS_B, 5'd12));
      decode_case("auipc", {u20, 5'd13, 7'b0010111}, {{(`XLEN-32){u20[19]}}, u20, 12'b0},
                  alu_ctrl(rv_isa_pkg::PC, rv_isa_pkg::IMM, rv_isa_pkg::ADD, 5'd13));
    end
    // r-type carries its i-field as the immediate
    inst = {7'b0100000, 5'd23, 5'd22, 3'b000, 5'd15, 7'b0110011};
    decode_case("sub", inst, sext12(inst[31:20]),
                alu_ctrl(rv_isa_pkg::RS1, rv_isa_pkg::RS2, rv_isa_pkg::SUB, 5'd15));
  endtask

  task automatic test_hazard();
    rv_isa_pkg::inst_t inst;
    inst = {7'b0000000, 5'd3, 5'd2, 3'b000, 5'd1, 7'b0110011}; // add x1,x2,x3
    for (int s = 0; s < 3; s++) begin
      set_hazards((s == 0) ? 5'd2 : 5'd0, (s == 1) ? 5'd2 : 5'd0, (s == 2) ? 5'd2 : 5'd0);
      issue(inst, 64'h1000);
      stall_then_release($sformatf("rs1 hazard from stage %0d", s));
    end
    issue({7'b0000000, 5'd0, 5'd0, 3'b000, 5'd4, 7'b0110011}, 64'h1004);
    check_valid("rd zero no stall", 1'b1, o_ds_to_es_valid);
    set_hazards('0, 5'd1, '0); // ebreak's rs2 field is 1
    issue(32'h0010_0073, 64'h1008);
    check_valid("ebreak ignores rs2", 1'b1, o_ds_to_es_valid);
    set_hazards('0, '0, 5'd10);
    issue(32'h0010_0073, 64'h100c);
    stall_then_release("ebreak on x10");
  endtask

  task automatic test_branches();
    rv_isa_pkg::br_func_e fns [6];
    logic [2:0]           f3;
    rv_isa_pkg::xlen_t    a;
    rv_isa_pkg::xlen_t    b;
    rv_isa_pkg::xlen_t    pc;
    logic [12:0]          off;
    logic [20:0]          joff;
    logic                 hit;
    id_pipe_pkg::br_bus_t exp;
    fns = '{rv_isa_pkg::BEQ, rv_isa_pkg::BNE, rv_isa_pkg::BLT, rv_isa_pkg::BGE,
            rv_isa_pkg::BLTU, rv_isa_pkg::BGEU};
    for (int k = 0; k < 12; k++) begin
      f3 = fns[k % 6];
      a  = rand64();
      b  = (k % 4 == 0) ? a : rand64();
      write_gpr(5'd8, a);
      write_gpr(5'd9, b);
      off    = $random(seed);
      off[0] = 1'b0;
      // funct3[2:1] picks the compare, funct3[0] inverts it
      hit = f3[2] ? (f3[1] ? (a < b) : ($signed(a) < $signed(b))) : (a == b);
      pc  = rand64() & ~64'h3;
      issue({off[12], off[10:5], 5'd9, 5'd8, f3, off[4:1], off[11], 7'b1100011}, pc);
      exp = '{taken: hit ^ f3[0], target: pc + {{(`XLEN-13){off[12]}}, off}};
      check_br($sformatf("branch funct3 %0d", f3), exp, o_br_bus);
    end
    joff    = $random(seed);
    joff[0] = 1'b0;
    issue({joff[20], joff[10:1], joff[11], joff[19:12], 5'd1, 7'b1101111}, pc);
    exp = '{taken: 1'b1, target: pc + {{(`XLEN-21){joff[20]}}, joff}};
    check_br("jal", exp, o_br_bus);
    off = $random(seed);
    issue({off[11:0], 5'd8, 3'b000, 5'd1, 7'b1100111}, pc);
    exp.target = (rd_model(5'd8) + sext12(off[11:0])) & ~64'h1;
    check_br("jalr", exp, o_br_bus);
    set_hazards(5'd8, '0, '0);
    issue({1'b0, 6'd2, 5'd8, 5'd8, 3'b000, 4'd0, 1'b0, 7'b1100011}, pc); // beq x8,x8,+64
    stall_then_release("beq under stall");
    exp.target = pc + 64'd64;
    check_br("beq after stall", exp, o_br_bus);
  endtask

  task automatic test_back_pressure();
    rv_isa_pkg::inst_t      a_inst;
    rv_isa_pkg::inst_t      b_inst;
    id_pipe_pkg::ds_to_es_t held;
    a_inst = {12'h123, 5'd4, 3'b000, 5'd9, 7'b0010011};
    b_inst = {12'hfff, 5'd6, 3'b000, 5'd10, 7'b0010011};
    @(negedge i_clk);
    i_es_allowin = 1'b0;
    issue(a_inst, 64'h2000);
    held = o_ds_to_es;
    check_ds_to_es("held item", exp_bus(a_inst, 64'h2000, sext12(12'h123),
                   alu_ctrl(rv_isa_pkg::RS1, rv_isa_pkg::IMM, rv_isa_pkg::ADD, 5'd9)), held);
    @(negedge i_clk);
    i_fs_to_ds_valid = 1'b1;
    i_fs_to_ds       = '{inst: b_inst, pc: 64'h2004};
    repeat (3) begin
      #10;
      check_valid("allowin under back-pressure", 1'b0, o_ds_allowin);
      check_ds_to_es("stable under back-pressure", held, o_ds_to_es);
      @(negedge i_clk);
    end
    i_es_allowin = 1'b1;
    @(negedge i_clk); // a left and b entered on this edge
    i_fs_to_ds_valid = 1'b0;
    #10;
    wait_out_valid("back-pressure release");
    check_ds_to_es("next item", exp_bus(b_inst, 64'h2004, sext12(12'hfff),
                   alu_ctrl(rv_isa_pkg::RS1, rv_isa_pkg::IMM, rv_isa_pkg::ADD, 5'd10)),
                   o_ds_to_es);
  endtask

  task automatic test_invalid();
    logic [6:0]        opc [2];
    rv_isa_pkg::inst_t inst;
    opc = '{7'b1111111, 7'b0001011};
    for (int k = 0; k < 2; k++) begin
      inst      = $random(seed);
      inst[6:0] = opc[k];
      issue(inst, 64'h3000);
      check_valid("invalid valid", 1'b1, o_ds_to_es_valid);
      check_valid("invalid flag", 1'b1, o_ds_to_es.ctrl.invalid);
      check_valid("invalid gpr_wen", 1'b0, o_ds_to_es.ctrl.gpr_wen);
      check_valid("invalid mem_ren", 1'b0, o_ds_to_es.ctrl.mem_ren);
      check_valid("invalid mem_wen", 1'b0, o_ds_to_es.ctrl.mem_wen);
    end
  endtask

  initial begin
    seed             = 32'h3528;
    i_rst            = 1'b1;
    i_fs_to_ds_valid = 1'b0;
    i_fs_to_ds       = '0;
    i_es_allowin     = 1'b1;
    i_wb_to_rf       = '0;
    i_es_rd          = '0;
    i_ms_rd          = '0;
    i_ws_rd          = '0;
    repeat (16) @(posedge i_clk);
    @(negedge i_clk);
    i_rst = 1'b0;
    #10;
    check_valid("valid after reset", 1'b0, o_ds_to_es_valid);
    check_valid("allowin after reset", 1'b1, o_ds_allowin);
    check_valid("redirect after reset", 1'b0, o_br_bus.taken);
    test_register_file();
    test_alu_decode();
    test_hazard();
    test_branches();
    test_back_pressure();
    test_invalid();
    $display("*** PASSED ***");
    $finish;
  end

endmodule

/* src/id_stage.sv */
// one-entry decode stage, no forwarding so raw hazards stall until the writer retires
`timescale 1ns/1ns

module id_stage (
  input  logic                   i_clk,
  input  logic                   i_rst,
  input  logic                   i_fs_to_ds_valid,
  input  id_pipe_pkg::fs_to_ds_t i_fs_to_ds,
  input  logic                   i_es_allowin,
  input  id_pipe_pkg::wb_to_rf_t i_wb_to_rf,
  input  rv_isa_pkg::reg_addr_t  i_es_rd,
  input  rv_isa_pkg::reg_addr_t  i_ms_rd,
  input  rv_isa_pkg::reg_addr_t  i_ws_rd,
  output logic                   o_ds_allowin,
  output logic                   o_ds_to_es_valid,
  output id_pipe_pkg::ds_to_es_t o_ds_to_es,
  output id_pipe_pkg::br_bus_t   o_br_bus
);

  logic                   ds_valid;
  logic                   ds_ready_go;
  logic                   ds_leave;
  id_pipe_pkg::fs_to_ds_t fs_to_ds_r;

  rv_isa_pkg::reg_addr_t rs1;
  rv_isa_pkg::reg_addr_t rs2;
  rv_isa_pkg::xlen_t     imm;
  rv_isa_pkg::xlen_t     rs1_data;
  rv_isa_pkg::xlen_t     rs2_data;
  id_pipe_pkg::ctrl_t    ctrl;
  logic                  br_en;
  logic                  jump;
  logic                  jalr;
  rv_isa_pkg::br_func_e  br_func;
  id_pipe_pkg::br_bus_t  br;

  assign o_ds_allowin     = !ds_valid || (ds_ready_go && i_es_allowin);
  assign o_ds_to_es_valid = ds_valid && ds_ready_go;
  assign ds_leave         = o_ds_to_es_valid && i_es_allowin;

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      ds_valid <= 1'b0;
    end else if (o_ds_allowin) begin
      ds_valid <= i_fs_to_ds_valid;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_fs_to_ds_valid && o_ds_allowin) begin
      fs_to_ds_r <= i_fs_to_ds;
    end
  end

  id_decoder u_decoder (
    .i_inst    (fs_to_ds_r.inst),
    .o_rs1     (rs1),
    .o_rs2     (rs2),
    .o_imm     (imm),
    .o_ctrl    (ctrl),
    .o_br_en   (br_en),
    .o_jump    (jump),
    .o_jalr    (jalr),
    .o_br_func (br_func)
  );

  id_gpr_file u_gpr_file (
    .i_clk    (i_clk),
    .i_raddr1 (rs1),
    .i_raddr2 (rs2),
    .i_wb     (i_wb_to_rf),
    .o_rdata1 (rs1_data),
    .o_rdata2 (rs2_data)
  );

  id_hazard_check u_hazard_check (
    .i_rs1      (rs1),
    .i_rs2      (rs2),
    .i_es_rd    (i_es_rd),
    .i_ms_rd    (i_ms_rd),
    .i_ws_rd    (i_ws_rd),
    .i_ebreak   (ctrl.ebreak),
    .o_ready_go (ds_ready_go)
  );

  id_branch_unit u_branch_unit (
    .i_pc       (fs_to_ds_r.pc),
    .i_rs1_data (rs1_data),
    .i_rs2_data (rs2_data),
    .i_imm      (imm),
    .i_br_en    (br_en),
    .i_jump     (jump),
    .i_jalr     (jalr),
    .i_br_func  (br_func),
    .o_br       (br)
  );

  // redirect fires once, on the edge the branch leaves
  assign o_br_bus.taken  = br.taken && ds_leave;
  assign o_br_bus.target = br.target;

  assign o_ds_to_es = '{
    rs1_data: rs1_data,
    rs2_data: rs2_data,
    imm:      imm,
    pc:       fs_to_ds_r.pc,
    ctrl:     ctrl
  };

endmodule

/* src/id_branch_unit.sv */
// raw taken decision, the caller must gate it with the stage's leave condition
`timescale 1ns/1ns

module id_branch_unit (
  input  rv_isa_pkg::xlen_t    i_pc,
  input  rv_isa_pkg::xlen_t    i_rs1_data,
  input  rv_isa_pkg::xlen_t    i_rs2_data,
  input  rv_isa_pkg::xlen_t    i_imm,
  input  logic                 i_br_en,
  input  logic                 i_jump,
  input  logic                 i_jalr,
  input  rv_isa_pkg::br_func_e i_br_func,
  output id_pipe_pkg::br_bus_t o_br
);

  logic              eq;
  logic              lt;
  logic              ltu;
  logic              cond;
  rv_isa_pkg::xlen_t base;
  rv_isa_pkg::xlen_t sum;

  assign eq  = (i_rs1_data == i_rs2_data);
  assign lt  = ($signed(i_rs1_data) < $signed(i_rs2_data));
  assign ltu = (i_rs1_data < i_rs2_data);

  always_comb begin
    case (i_br_func)
      rv_isa_pkg::BEQ:  cond = eq;
      rv_isa_pkg::BNE:  cond = !eq;
      rv_isa_pkg::BLT:  cond = lt;
      rv_isa_pkg::BGE:  cond = !lt;
      rv_isa_pkg::BLTU: cond = ltu;
      rv_isa_pkg::BGEU: cond = !ltu;
      default:          cond = 1'b0;
    endcase
  end

  // one adder for all targets
  assign base = i_jalr ? i_rs1_data : i_pc;
  assign sum  = base + i_imm;

  assign o_br.taken  = i_jump || i_jalr || (i_br_en && cond);
  assign o_br.target = i_jalr ? (sum & ~rv_isa_pkg::xlen_t'(1)) : sum; // jalr clears bit 0

endmodule

/* src/id_hazard_check.sv */
// stalls on any pending write to a source register, no forwarding; rd of zero means no write
`timescale 1ns/1ns

module id_hazard_check (
  input  rv_isa_pkg::reg_addr_t i_rs1,
  input  rv_isa_pkg::reg_addr_t i_rs2,
  input  rv_isa_pkg::reg_addr_t i_es_rd,
  input  rv_isa_pkg::reg_addr_t i_ms_rd,
  input  rv_isa_pkg::reg_addr_t i_ws_rd,
  input  logic                  i_ebreak,
  output logic                  o_ready_go
);

  // ebreak only reads a0, the exit code
  localparam rv_isa_pkg::reg_addr_t EBREAK_REG = 5'd10;

  function automatic logic rd_hit(input rv_isa_pkg::reg_addr_t rd,
                                  input rv_isa_pkg::reg_addr_t rs1,
                                  input rv_isa_pkg::reg_addr_t rs2,
                                  input logic                  ebreak);
    logic src_hit;
    src_hit = ebreak ? (rd == EBREAK_REG) : (rd == rs1 || rd == rs2);
    return (rd != '0) && src_hit;
  endfunction

  assign o_ready_go = !(rd_hit(i_es_rd, i_rs1, i_rs2, i_ebreak) ||
                        rd_hit(i_ms_rd, i_rs1, i_rs2, i_ebreak) ||
                        rd_hit(i_ws_rd, i_rs1, i_rs2, i_ebreak));

endmodule

/* src/id_gpr_file.sv */
// x0 is hardwired to zero; no write-to-read bypass, a written value shows the cycle after
`timescale 1ns/1ns
`include "id_defines.svh"

module id_gpr_file (
  input  logic                   i_clk,
  input  rv_isa_pkg::reg_addr_t  i_raddr1,
  input  rv_isa_pkg::reg_addr_t  i_raddr2,
  input  id_pipe_pkg::wb_to_rf_t i_wb,
  output rv_isa_pkg::xlen_t      o_rdata1,
  output rv_isa_pkg::xlen_t      o_rdata2
);

  rv_isa_pkg::xlen_t regs [`NUM_GPR];

  // entry 0 is never written
  always_ff @(posedge i_clk) begin
    if (i_wb.wen && i_wb.waddr != '0) begin
      regs[i_wb.waddr] <= i_wb.wdata;
    end
  end

  // async reads
  assign o_rdata1 = (i_raddr1 == '0) ? '0 : regs[i_raddr1];
  assign o_rdata2 = (i_raddr2 == '0) ? '0 : regs[i_raddr2];

endmodule

/* src/id_decoder.sv */
// decodes LUI/AUIPC/JAL/JALR/Bxx/LD/SD/ADDI/ADD/SUB/EBREAK only, all else is flagged invalid
`timescale 1ns/1ns
`include "id_defines.svh"

module id_decoder (
  input  rv_isa_pkg::inst_t     i_inst,
  output rv_isa_pkg::reg_addr_t o_rs1,
  output rv_isa_pkg::reg_addr_t o_rs2,
  output rv_isa_pkg::xlen_t     o_imm,
  output id_pipe_pkg::ctrl_t    o_ctrl,
  output logic                  o_br_en,
  output logic                  o_jump,
  output logic                  o_jalr,
  output rv_isa_pkg::br_func_e  o_br_func
);

  localparam rv_isa_pkg::inst_t EBREAK_INST = 32'h0010_0073;

  rv_isa_pkg::opcode_e   opcode;
  rv_isa_pkg::reg_addr_t rd;
  rv_isa_pkg::funct3_t   funct3;
  logic [6:0]            funct7;

  rv_isa_pkg::xlen_t imm_i;
  rv_isa_pkg::xlen_t imm_s;
  rv_isa_pkg::xlen_t imm_b;
  rv_isa_pkg::xlen_t imm_u;
  rv_isa_pkg::xlen_t imm_j;

  id_pipe_pkg::ctrl_t ctrl;

  assign opcode = rv_isa_pkg::opcode_e'(i_inst[6:0]);
  assign rd     = i_inst[11:7];
  assign funct3 = i_inst[14:12];
  assign funct7 = i_inst[31:25];

  // source fields go out raw, the hazard check compares them for every format
  assign o_rs1 = i_inst[19:15];
  assign o_rs2 = i_inst[24:20];

  assign imm_i = {{(`XLEN-12){i_inst[31]}}, i_inst[31:20]};
  assign imm_s = {{(`XLEN-12){i_inst[31]}}, i_inst[31:25], i_inst[11:7]};
  assign imm_b = {{(`XLEN-13){i_inst[31]}}, i_inst[31], i_inst[7], i_inst[30:25],
                  i_inst[11:8], 1'b0};
  assign imm_u = {{(`XLEN-32){i_inst[31]}}, i_inst[31:12], 12'b0};
  assign imm_j = {{(`XLEN-21){i_inst[31]}}, i_inst[31], i_inst[19:12], i_inst[20],
                  i_inst[30:21], 1'b0};

  assign o_br_func = rv_isa_pkg::br_func_e'(funct3); // only looked at when o_br_en

  always_comb begin
    ctrl          = '0;
    ctrl.src1_sel = rv_isa_pkg::RS1;
    ctrl.src2_sel = rv_isa_pkg::IMM;
    ctrl.alu_op   = rv_isa_pkg::ADD;
    o_imm         = imm_i;
    o_br_en       = 1'b0;
    o_jump        = 1'b0;
    o_jalr        = 1'b0;

    case (opcode)
      rv_isa_pkg::LUI: begin
        ctrl.alu_op  = rv_isa_pkg::PASS_B;
        ctrl.gpr_wen = 1'b1;
        o_imm        = imm_u;
      end
      rv_isa_pkg::AUIPC: begin
        ctrl.src1_sel = rv_isa_pkg::PC;
        ctrl.gpr_wen  = 1'b1;
        o_imm         = imm_u;
      end
      rv_isa_pkg::JAL: begin
        ctrl.src1_sel = rv_isa_pkg::PC; // link = pc + 4
        ctrl.src2_sel = rv_isa_pkg::FOUR;
        ctrl.gpr_wen  = 1'b1;
        o_imm         = imm_j;
        o_jump        = 1'b1;
      end
      rv_isa_pkg::JALR: begin
        if (funct3 == 3'b000) begin
          ctrl.src1_sel = rv_isa_pkg::PC;
          ctrl.src2_sel = rv_isa_pkg::FOUR;
          ctrl.gpr_wen  = 1'b1;
          o_jalr        = 1'b1;
        end else begin
          ctrl.invalid = 1'b1;
        end
      end
      rv_isa_pkg::BRANCH: begin
        o_imm = imm_b;
        if (funct3[2:1] == 2'b01) ctrl.invalid = 1'b1;
        else                      o_br_en      = 1'b1;
      end
      rv_isa_pkg::LOAD: begin
        if (funct3 == 3'b011) begin // ld
          ctrl.gpr_wen    = 1'b1;
          ctrl.mem_ren    = 1'b1;
          ctrl.mem_funct3 = funct3;
        end else begin
          ctrl.invalid = 1'b1;
        end
      end
      rv_isa_pkg::STORE: begin
        o_imm = imm_s;
        if (funct3 == 3'b011) begin // sd
          ctrl.mem_wen    = 1'b1;
          ctrl.mem_funct3 = funct3;
        end else begin
          ctrl.invalid = 1'b1;
        end
      end
      rv_isa_pkg::OP_IMM: begin
        if (funct3 == 3'b000) ctrl.gpr_wen = 1'b1; // addi
        else                  ctrl.invalid = 1'b1;
      end
      rv_isa_pkg::OP: begin
        ctrl.src2_sel = rv_isa_pkg::RS2;
        if (funct3 == 3'b000 && funct7 == 7'b0000000) begin
          ctrl.gpr_wen = 1'b1;
        end else if (funct3 == 3'b000 && funct7 == 7'b0100000) begin
          ctrl.alu_op  = rv_isa_pkg::SUB;
          ctrl.gpr_wen = 1'b1;
        end else begin
          ctrl.invalid = 1'b1;
        end
      end
      rv_isa_pkg::SYSTEM: begin
        if (i_inst == EBREAK_INST) ctrl.ebreak  = 1'b1;
        else                       ctrl.invalid = 1'b1;
      end
      default: ctrl.invalid = 1'b1;
    endcase

    ctrl.rd = ctrl.gpr_wen ? rd : '0; // downstream treats rd 0 as no write
  end

  assign o_ctrl = ctrl;

endmodule

/* src/id_pipe_pkg.sv */
// bus layouts around the decode stage; field order is fixed, neighbouring stages unpack by name
package id_pipe_pkg;

  // fetch to decode with inst on top
  typedef struct packed {
    rv_isa_pkg::inst_t inst;
    rv_isa_pkg::xlen_t pc;
  } fs_to_ds_t;

  // decoded control carried to execute and beyond
  typedef struct packed {
    rv_isa_pkg::src1_sel_e src1_sel;
    rv_isa_pkg::src2_sel_e src2_sel;
    rv_isa_pkg::alu_op_e   alu_op;
    rv_isa_pkg::reg_addr_t rd;         // zero when nothing is written
    logic                  gpr_wen;
    logic                  mem_ren;
    logic                  mem_wen;
    rv_isa_pkg::funct3_t   mem_funct3; // access size for ld/sd only
    logic                  ebreak;
    logic                  invalid;
  } ctrl_t;

  // decode to execute
  typedef struct packed {
    rv_isa_pkg::xlen_t rs1_data;
    rv_isa_pkg::xlen_t rs2_data;
    rv_isa_pkg::xlen_t imm;
    rv_isa_pkg::xlen_t pc;
    ctrl_t             ctrl;
  } ds_to_es_t;

  // redirect to fetch
  typedef struct packed {
    logic              taken;
    rv_isa_pkg::xlen_t target;
  } br_bus_t;

  // write-back port of the gpr file
  typedef struct packed {
    logic                  wen;
    rv_isa_pkg::reg_addr_t waddr;
    rv_isa_pkg::xlen_t     wdata;
  } wb_to_rf_t;

endpackage

/* src/rv_isa_pkg.sv */
// RV64I subset encodings only; funct3 values outside the enums are left to the decoder to reject
`include "id_defines.svh"

package rv_isa_pkg;

  typedef logic [`XLEN-1:0]   xlen_t;
  typedef logic [`ILEN-1:0]   inst_t;
  typedef logic [`REG_AW-1:0] reg_addr_t;
  typedef logic [2:0]         funct3_t;

  // major opcodes in bits [6:0]
  typedef enum logic [6:0] {
    LUI    = 7'b0110111,
    AUIPC  = 7'b0010111,
    JAL    = 7'b1101111,
    JALR   = 7'b1100111,
    BRANCH = 7'b1100011,
    LOAD   = 7'b0000011,
    STORE  = 7'b0100011,
    OP_IMM = 7'b0010011,
    OP     = 7'b0110011,
    SYSTEM = 7'b1110011
  } opcode_e;

  // branch funct3 codes (3'b010 and 3'b011 reserved)
  typedef enum logic [2:0] {
    BEQ  = 3'b000,
    BNE  = 3'b001,
    BLT  = 3'b100,
    BGE  = 3'b101,
    BLTU = 3'b110,
    BGEU = 3'b111
  } br_func_e;

  typedef enum logic [1:0] {
    ADD    = 2'd0,
    SUB    = 2'd1,
    PASS_B = 2'd2 // lui passes operand b straight through
  } alu_op_e;

  // alu operand a
  typedef enum logic {
    RS1 = 1'b0,
    PC  = 1'b1
  } src1_sel_e;

  // operand b where FOUR gives the link address of jal/jalr
  typedef enum logic [1:0] {
    RS2  = 2'd0,
    IMM  = 2'd1,
    FOUR = 2'd2
  } src2_sel_e;

endpackage

/* src/id_defines.svh */
// widths shared by the decode stage; XLEN must stay 64, the immediates assume RV64
`ifndef ID_DEFINES_SVH
`define ID_DEFINES_SVH

// data and pc width
`define XLEN 64

// instruction word, no compressed support
`define ILEN 32

`define REG_AW 5   // gpr index width
`define NUM_GPR 32 // count includes x0 which reads as zero

`endif
